//--- src/spi_pkg.sv
/*
 * SPI bus definitions shared by the byte masters, the transfer interface
 * and the pair controller. Import with spi_pkg::* inside a module body,
 * or use scoped names in a module header.
 */
package spi_pkg;

    // ------------------------------------------------------------------------
    // serial line data
    // ------------------------------------------------------------------------
    typedef logic [7:0] spi_byte_t;             // one byte on mosi / miso

    // system clocks per half serial period, f_sclk = f_clk / (2 * div)
    parameter int SPI_CLK_DIV_DEF = 4;

    // ------------------------------------------------------------------------
    // byte master FSM
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'd0,                          // cs_n high, waiting for start
        SELECT = 2'd1,                          // cs_n low, sclk still low
        SHIFT  = 2'd2,                          // 16 half periods of sclk
        DONE   = 2'd3                           // rx byte valid, done pulse
    } spi_state_t;

endpackage

//--- src/sensor_pkg.sv
/*
 * Sensor sample definitions for the redundant pair reader.
 * Holds the reading, average and difference types, the default fault
 * tolerance and the pair controller state encoding.
 */
package sensor_pkg;

    // ------------------------------------------------------------------------
    // sample data
    // ------------------------------------------------------------------------
    typedef logic [7:0] sample_t;               // raw reading or floor average
    typedef logic [7:0] diff_t;                 // |a - b|, never wider than a reading

    // largest difference still treated as agreement
    parameter int TOLERANCE_DEF = 8;

    // ------------------------------------------------------------------------
    // pair controller FSM
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'd0,                          // accepts sample_req
        WAIT   = 2'd1,                          // both masters shifting
        REPORT = 2'd2                           // one cycle, sample_valid high
    } pair_state_t;

endpackage

//--- src/spi_xfer_if.sv
/*
 * One byte transfer between the pair controller (host) and one SPI byte
 * master (dev). start and done are single-cycle strobes; rx_byte holds
 * from done until the next start.
 */
`timescale 1ns/1ps

interface spi_xfer_if;
    import spi_pkg::*;

    logic      start;                           // host -> dev, only while dev idle
    spi_byte_t tx_byte;                         // sampled in the start cycle
    logic      done;                            // dev -> host, one per start
    spi_byte_t rx_byte;                         // byte shifted in from miso

    modport host (
        output start,
        output tx_byte,
        input  done,
        input  rx_byte
    );

    modport dev (
        input  start,
        input  tx_byte,
        output done,
        output rx_byte
    );

endinterface

//--- src/spi_byte_master.sv
/*
 * SPI Mode-1 master (CPOL 0, CPHA 1) moving one full-duplex byte per start.
 * mosi changes on rising sclk, MSB first; miso is sampled on falling sclk.
 * sclk runs at f_clk / (2 * CLK_DIV); cs_n is low from SELECT through DONE.
 */
`timescale 1ns/1ps

module spi_byte_master #(
    parameter int CLK_DIV = spi_pkg::SPI_CLK_DIV_DEF   // >= 2
) (
    input  logic       clk,
    input  logic       rst,
    spi_xfer_if.dev    xfer,
    input  logic       miso,
    output logic       sclk,
    output logic       mosi,
    output logic       cs_n
);
    import spi_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV);

    spi_state_t       state;
    spi_state_t       state_nxt;
    logic [DIV_W-1:0] div_cnt;                  // system clocks within half period
    logic             tick;                     // last clock of a half period
    logic             rise;                     // tick that drives sclk high
    logic             fall;                     // tick that drives sclk low
    logic             last_fall;                // 8th falling edge
    logic [2:0]       bit_cnt;                  // falling edges seen so far
    spi_byte_t        tx_shift;
    spi_byte_t        rx_shift;
    spi_byte_t        rx_byte;

    if (CLK_DIV < 2) begin : g_div_check
        $error("spi_byte_master needs CLK_DIV of at least 2");
    end

    // ------------------------------------------------------------------------
    // half period timing
    // ------------------------------------------------------------------------
    assign tick      = (state == SHIFT) && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign rise      = tick && !sclk;           // sclk idles low, so odd ticks rise
    assign fall      = tick && sclk;
    assign last_fall = fall && (bit_cnt == 3'd7);

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (xfer.start) state_nxt = SELECT;
            SELECT:  state_nxt = SHIFT;         // select setup, one clock
            SHIFT:   if (last_fall) state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            div_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            bit_cnt <= 3'd0;
        end else begin
            state <= state_nxt;

            if (state == SHIFT && !tick)
                div_cnt <= div_cnt + 1'b1;
            else
                div_cnt <= '0;                  // restart each half period

            if (tick)
                sclk <= ~sclk;                  // 16th tick leaves it low again

            if (rise)
                mosi <= tx_shift[7];            // MSB first
            else if (state == IDLE)
                mosi <= 1'b0;

            if (state == SELECT)
                bit_cnt <= 3'd0;
            else if (fall)
                bit_cnt <= bit_cnt + 1'b1;      // wraps to 0 on the last edge
        end
    end

    // ------------------------------------------------------------------------
    // shift registers and received byte
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == IDLE && xfer.start)
            tx_shift <= xfer.tx_byte;           // capture in the start cycle
        else if (rise)
            tx_shift <= {tx_shift[6:0], 1'b0};

        if (fall)
            rx_shift <= {rx_shift[6:0], miso};

        // last bit goes straight into the held copy, valid in DONE
        if (last_fall)
            rx_byte <= {rx_shift[6:0], miso};
    end

    assign cs_n         = (state == IDLE);
    assign xfer.done    = (state == DONE);
    assign xfer.rx_byte = rx_byte;              // stable until the next last_fall

endmodule

//--- src/sensor_pair_ctrl.sv
/*
 * Pair controller for two redundant sensors. On sample_req it starts both
 * SPI byte masters with the same register address, gathers both readings
 * in either order and reports floor average, absolute difference and fault.
 */
`timescale 1ns/1ps

module sensor_pair_ctrl #(
    parameter int TOLERANCE = sensor_pkg::TOLERANCE_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                sample_req,     // dropped while busy
    input  spi_pkg::spi_byte_t  reg_addr,
    spi_xfer_if.host            xfer_a,
    spi_xfer_if.host            xfer_b,
    output logic                busy,
    output logic                sample_valid,
    output sensor_pkg::sample_t sample_avg,
    output sensor_pkg::diff_t   sample_diff,
    output logic                fault
);
    import sensor_pkg::*;

    localparam int SUM_W = $bits(sample_t) + 1;

    pair_state_t      state;
    pair_state_t      state_nxt;
    logic             launch;                   // accepted request
    logic             start_q;                  // start strobe to both masters
    sample_t          addr_q;
    logic             got_a;                    // reading a already latched
    logic             got_b;
    logic             both_in;
    sample_t          read_a;
    sample_t          read_b;
    sample_t          cur_a;                    // reading a, incl. this cycle's done
    sample_t          cur_b;
    logic [SUM_W-1:0] sum;
    diff_t            diff;

    assign launch = (state == IDLE) && sample_req;

    // a reading counts if already stored or arriving right now
    assign cur_a   = xfer_a.done ? xfer_a.rx_byte : read_a;
    assign cur_b   = xfer_b.done ? xfer_b.rx_byte : read_b;
    assign both_in = (got_a || xfer_a.done) && (got_b || xfer_b.done);

    // ------------------------------------------------------------------------
    // result arithmetic
    // ------------------------------------------------------------------------
    assign sum  = {1'b0, cur_a} + {1'b0, cur_b}; // nine bits, no overflow
    assign diff = (cur_a >= cur_b) ? (cur_a - cur_b) : (cur_b - cur_a);

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (sample_req) state_nxt = WAIT;
            WAIT:    if (both_in) state_nxt = REPORT;
            REPORT:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            start_q     <= 1'b0;
            got_a       <= 1'b0;
            got_b       <= 1'b0;
            sample_avg  <= '0;
            sample_diff <= '0;
            fault       <= 1'b0;
        end else begin
            state   <= state_nxt;
            start_q <= launch;                  // one cycle after the request

            if (state == IDLE) begin
                got_a <= 1'b0;
                got_b <= 1'b0;
            end else begin
                if (xfer_a.done) got_a <= 1'b1;
                if (xfer_b.done) got_b <= 1'b1;
            end

            // results land as REPORT starts, then hold
            if (state == WAIT && both_in) begin
                sample_avg  <= sum[SUM_W-1:1];  // floor of sum / 2
                sample_diff <= diff;
                fault       <= (diff > diff_t'(TOLERANCE));
            end
        end
    end

    // payload, only meaningful once the matching flag is set
    always_ff @(posedge clk) begin
        if (launch)
            addr_q <= reg_addr;
        if (xfer_a.done)
            read_a <= xfer_a.rx_byte;
        if (xfer_b.done)
            read_b <= xfer_b.rx_byte;
    end

    assign xfer_a.start   = start_q;
    assign xfer_b.start   = start_q;
    assign xfer_a.tx_byte = addr_q;             // same address to both sensors
    assign xfer_b.tx_byte = addr_q;

    assign busy         = (state != IDLE);
    assign sample_valid = (state == REPORT);

endmodule

//--- src/dual_sensor_reader.sv
/*
 * Top level of the redundant sensor pair reader. Two independent Mode-1
 * SPI buses read the same register from two sensors; results come out
 * with a one-cycle sample_valid strobe.
 */
`timescale 1ns/1ps

module dual_sensor_reader #(
    parameter int CLK_DIV   = spi_pkg::SPI_CLK_DIV_DEF,
    parameter int TOLERANCE = sensor_pkg::TOLERANCE_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                sample_req,     // one-cycle request
    input  spi_pkg::spi_byte_t  reg_addr,       // address sent on both buses
    input  logic                miso_a,
    input  logic                miso_b,
    // ------------------------------------------------------------------------
    // SPI buses
    // ------------------------------------------------------------------------
    output logic                sclk_a,
    output logic                mosi_a,
    output logic                cs_n_a,
    output logic                sclk_b,
    output logic                mosi_b,
    output logic                cs_n_b,
    // ------------------------------------------------------------------------
    // results
    // ------------------------------------------------------------------------
    output logic                busy,
    output logic                sample_valid,
    output sensor_pkg::sample_t sample_avg,
    output sensor_pkg::diff_t   sample_diff,
    output logic                fault
);

    spi_xfer_if if_a ();                        // controller <-> master a
    spi_xfer_if if_b ();                        // controller <-> master b

    spi_byte_master #(
        .CLK_DIV (CLK_DIV)
    ) i_master_a (
        .clk  (clk),
        .rst  (rst),
        .xfer (if_a.dev),
        .miso (miso_a),
        .sclk (sclk_a),
        .mosi (mosi_a),
        .cs_n (cs_n_a)
    );

    spi_byte_master #(
        .CLK_DIV (CLK_DIV)
    ) i_master_b (
        .clk  (clk),
        .rst  (rst),
        .xfer (if_b.dev),
        .miso (miso_b),
        .sclk (sclk_b),
        .mosi (mosi_b),
        .cs_n (cs_n_b)
    );

    sensor_pair_ctrl #(
        .TOLERANCE (TOLERANCE)
    ) i_pair_ctrl (
        .clk          (clk),
        .rst          (rst),
        .sample_req   (sample_req),
        .reg_addr     (reg_addr),
        .xfer_a       (if_a.host),
        .xfer_b       (if_b.host),
        .busy         (busy),
        .sample_valid (sample_valid),
        .sample_avg   (sample_avg),
        .sample_diff  (sample_diff),
        .fault        (fault)
    );

endmodule

//--- verif/spi_sensor_model.sv
/*
 * Behavioral Mode-1 SPI sensor for the testbench. Shifts out a preset
 * reply on rising sclk while selected and records the byte seen on mosi.
 * rx_count goes up by one for every complete byte.
 */
`timescale 1ns/1ps

module spi_sensor_model (
    input  logic        sclk,
    input  logic        cs_n,
    input  logic        mosi,
    output logic        miso,
    input  logic [7:0]  reply,          // value returned to the master
    output logic [7:0]  rx_byte,        // last complete byte from mosi
    output logic [15:0] rx_count
);
    logic [2:0]  bit_idx  = 3'd0;       // falling edges within the byte
    logic [7:0]  shift_in = 8'h00;
    logic [7:0]  last_rx  = 8'h00;
    logic [15:0] n_bytes  = 16'd0;
    logic        out_bit  = 1'b0;

    // mode 1, data changes on the leading (rising) edge, MSB first
    always @(posedge sclk) begin
        if (!cs_n)
            out_bit <= reply[3'd7 - bit_idx];
    end

    // sample mosi on the trailing edge
    always @(negedge sclk) begin
        if (!cs_n) begin
            shift_in <= {shift_in[6:0], mosi};
            bit_idx  <= bit_idx + 3'd1;     // wraps after eight bits
            if (bit_idx == 3'd7) begin
                last_rx <= {shift_in[6:0], mosi};
                n_bytes <= n_bytes + 16'd1;
            end
        end
    end

    assign miso     = out_bit;
    assign rx_byte  = last_rx;
    assign rx_count = n_bytes;

endmodule

//--- verif/dual_sensor_reader_chk.sv
/*
 * Protocol checker bound into the reader top level. Watches the SPI idle
 * levels, the sample_valid strobe width and busy against both selects.
 */
`timescale 1ns/1ps

module dual_sensor_reader_chk (
    input logic clk,
    input logic rst,
    input logic cs_n_a,
    input logic cs_n_b,
    input logic sclk_a,
    input logic sclk_b,
    input logic busy,
    input logic sample_valid
);

    int unsigned n_fail = 0;            // failed assertions so far

    // ------------------------------------------------------------------------
    // bus idle levels
    // ------------------------------------------------------------------------
    a_reset_idle: assert property (@(posedge clk)
        rst |=> (cs_n_a && cs_n_b && !sclk_a && !sclk_b))
        else begin
            $error("SPI buses not idle during or after reset");
            n_fail++;
        end

    a_sclk_idle_a: assert property (@(posedge clk) disable iff (rst)
        cs_n_a |-> !sclk_a)             // clock parks low while deselected
        else begin
            $error("sclk_a high while cs_n_a is high");
            n_fail++;
        end

    a_sclk_idle_b: assert property (@(posedge clk) disable iff (rst)
        cs_n_b |-> !sclk_b)
        else begin
            $error("sclk_b high while cs_n_b is high");
            n_fail++;
        end

    // ------------------------------------------------------------------------
    // controller strobes
    // ------------------------------------------------------------------------
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        sample_valid |=> !sample_valid)
        else begin
            $error("sample_valid held for more than one cycle");
            n_fail++;
        end

    a_busy_cover: assert property (@(posedge clk) disable iff (rst)
        (!cs_n_a || !cs_n_b) |-> busy)  // any open transfer means busy
        else begin
            $error("a select is low while busy is low");
            n_fail++;
        end

endmodule

//--- verif/tb_dual_sensor_reader.sv
/*
 * Testbench for the redundant sensor pair reader. Two SPI sensor models
 * answer requests taken from a table of fixed and random rows; results,
 * received addresses, dropped requests and held outputs are checked.
 */
`timescale 1ns/1ps

module tb_dual_sensor_reader;

    localparam int CLK_PERIOD   = 4;
    localparam int CLK_DIV      = 4;
    localparam int TOLERANCE    = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_FIXED      = 9;
    localparam int N_RANDOM     = 8;
    localparam int N_ROWS       = N_FIXED + N_RANDOM;
    localparam int XFER_CYCLES  = 16 * CLK_DIV + 20;   // request to valid, with slack
    localparam int DUP_IDLE     = 16;                  // quiet window after a dropped request
    localparam int WATCHDOG     = N_ROWS * (XFER_CYCLES + DUP_IDLE) + RESET_CYCLES + 100;
    localparam logic [31:0] SEED = 32'hcf2ce354;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] reply_a;
        logic [7:0] reply_b;
        logic       dup;                // pulse a second request while busy
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        sample_req;
    logic [7:0]  reg_addr;
    logic        miso_a, mosi_a, sclk_a, cs_n_a;
    logic        miso_b, mosi_b, sclk_b, cs_n_b;
    logic        busy, sample_valid, fault;
    logic [7:0]  sample_avg, sample_diff;
    logic [7:0]  reply_a, reply_b;      // preset sensor answers
    logic [7:0]  rx_a, rx_b;
    logic [15:0] count_a, count_b;
    logic [7:0]  hold_avg   = 8'h00;    // last reported results, zero after reset
    logic [7:0]  hold_diff  = 8'h00;
    logic        hold_fault = 1'b0;
    row_t        table_rows [N_ROWS];

    always #(CLK_PERIOD / 2) clk = ~clk;

    dual_sensor_reader #(
        .CLK_DIV   (CLK_DIV),
        .TOLERANCE (TOLERANCE)
    ) i_dual_sensor_reader (
        .clk          (clk),
        .rst          (rst),
        .sample_req   (sample_req),
        .reg_addr     (reg_addr),
        .miso_a       (miso_a),
        .miso_b       (miso_b),
        .sclk_a       (sclk_a),
        .mosi_a       (mosi_a),
        .cs_n_a       (cs_n_a),
        .sclk_b       (sclk_b),
        .mosi_b       (mosi_b),
        .cs_n_b       (cs_n_b),
        .busy         (busy),
        .sample_valid (sample_valid),
        .sample_avg   (sample_avg),
        .sample_diff  (sample_diff),
        .fault        (fault)
    );

    spi_sensor_model i_sensor_a (
        .sclk (sclk_a), .cs_n (cs_n_a), .mosi (mosi_a), .miso (miso_a),
        .reply (reply_a), .rx_byte (rx_a), .rx_count (count_a)
    );

    spi_sensor_model i_sensor_b (
        .sclk (sclk_b), .cs_n (cs_n_b), .mosi (mosi_b), .miso (miso_b),
        .reply (reply_b), .rx_byte (rx_b), .rx_count (count_b)
    );

    bind dual_sensor_reader dual_sensor_reader_chk i_chk (
        .clk (clk), .rst (rst), .cs_n_a (cs_n_a), .cs_n_b (cs_n_b),
        .sclk_a (sclk_a), .sclk_b (sclk_b), .busy (busy), .sample_valid (sample_valid)
    );

    // ------------------------------------------------------------------------
    // checking helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_results(input logic [7:0] avg, input logic [7:0] diff,
                                 input logic flt);
        check_value("sample_avg", 32'(sample_avg), 32'(avg));
        check_value("sample_diff", 32'(sample_diff), 32'(diff));
        check_value("fault", 32'(fault), 32'(flt));
    endtask

    // floor average, absolute difference, fault above tolerance
    task automatic expected_result(input logic [7:0] a, input logic [7:0] b,
                                   output logic [7:0] avg, output logic [7:0] diff,
                                   output logic flt);
        int sa;
        int sb;
        int d;
        sa   = int'(a);
        sb   = int'(b);
        d    = (sa > sb) ? sa - sb : sb - sa;
        avg  = 8'((sa + sb) / 2);
        diff = 8'(d);
        flt  = (d > TOLERANCE);
    endtask

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic load_table();
        int         i;
        logic [7:0] a;
        table_rows[0] = '{8'h3c, 8'h40, 8'h40, 1'b0};  // equal readings
        table_rows[1] = '{8'ha5, 8'h00, 8'hff, 1'b1};  // full scale apart
        table_rows[2] = '{8'h5a, 8'hff, 8'hff, 1'b0};
        table_rows[3] = '{8'h01, 8'h00, 8'h00, 1'b0};
        table_rows[4] = '{8'h80, 8'h10, 8'h18, 1'b0};  // diff 8, still ok
        table_rows[5] = '{8'h7f, 8'h18, 8'h0f, 1'b1};  // diff 9, fault
        table_rows[6] = '{8'hc3, 8'h21, 8'h20, 1'b0};  // odd sum rounds down
        table_rows[7] = '{8'h0f, 8'hf7, 8'hff, 1'b1};
        table_rows[8] = '{8'hf0, 8'hff, 8'hf6, 1'b0};
        for (i = N_FIXED; i < N_ROWS; i++) begin
            a = 8'($urandom);
            table_rows[i].addr    = 8'($urandom);
            table_rows[i].reply_a = a;
            // every other row stays near the tolerance boundary
            if (i % 2 == 0)
                table_rows[i].reply_b = a + 8'($urandom % 17);
            else
                table_rows[i].reply_b = 8'($urandom);
            table_rows[i].dup = (i % 3 == 0);
        end
    endtask

    task automatic run_row(input row_t r);
        logic [7:0]  exp_avg;
        logic [7:0]  exp_diff;
        logic        exp_fault;
        logic [15:0] cnt_a;
        logic [15:0] cnt_b;
        int          cycles;
        expected_result(r.reply_a, r.reply_b, exp_avg, exp_diff, exp_fault);
        cnt_a      = count_a;
        cnt_b      = count_b;
        reply_a    = r.reply_a;
        reply_b    = r.reply_b;
        sample_req = 1'b1;
        reg_addr   = r.addr;
        cycles     = 0;
        @(negedge clk);
        reg_addr = ~r.addr;             // address only counts in the request cycle
        while (sample_valid !== 1'b1) begin
            check_results(hold_avg, hold_diff, hold_fault);
            sample_req = r.dup && (cycles == 4 * CLK_DIV);
            if (sample_req)
                check_value("busy", 32'(busy), 32'd1);
            @(negedge clk);
            cycles++;
            if (cycles > XFER_CYCLES)
                fail_now("timeout: no sample_valid seen for the current request");
        end
        sample_req = 1'b0;
        check_results(exp_avg, exp_diff, exp_fault);
        check_value("sensor_a rx_byte", 32'(rx_a), 32'(r.addr));
        check_value("sensor_b rx_byte", 32'(rx_b), 32'(r.addr));
        hold_avg   = exp_avg;
        hold_diff  = exp_diff;
        hold_fault = exp_fault;
        // dropped requests must not start anything afterwards
        repeat (r.dup ? DUP_IDLE : 2) begin
            @(negedge clk);
            check_value("sample_valid", 32'(sample_valid), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
            check_results(hold_avg, hold_diff, hold_fault);
        end
        check_value("sensor_a rx_count", 32'(count_a), 32'(cnt_a + 16'd1));
        check_value("sensor_b rx_count", 32'(count_b), 32'(cnt_b + 16'd1));
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        int i;
        rst        = 1'b1;
        sample_req = 1'b0;
        reg_addr   = 8'h00;
        reply_a    = 8'h00;
        reply_b    = 8'h00;
        void'($urandom(SEED));
        load_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("cs_n_a", 32'(cs_n_a), 32'd1);
        check_value("cs_n_b", 32'(cs_n_b), 32'd1);
        check_value("sclk_a", 32'(sclk_a), 32'd0);
        check_value("sclk_b", 32'(sclk_b), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("fault", 32'(fault), 32'd0);
        for (i = 0; i < N_ROWS; i++)
            run_row(table_rows[i]);
        if (i_dual_sensor_reader.i_chk.n_fail != 0)
            fail_now("protocol assertion failed in the bound checker");
        else begin
            $display("sim passed");
            $finish;
        end
    end

    // stop at the first protocol error seen by the checker
    always @(negedge clk) begin
        if (i_dual_sensor_reader.i_chk.n_fail != 0)
            fail_now("protocol assertion failed in the bound checker");
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        fail_now("timeout: watchdog expired before all table rows finished");
    end

endmodule

//--- src.f
src/spi_pkg.sv
src/sensor_pkg.sv
src/spi_xfer_if.sv
src/spi_byte_master.sv
src/sensor_pair_ctrl.sv
src/dual_sensor_reader.sv
verif/spi_sensor_model.sv
verif/dual_sensor_reader_chk.sv
verif/tb_dual_sensor_reader.sv

//--- Makefile
# Verilator build for the dual sensor reader testbench
TOP := tb_dual_sensor_reader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail, the simulator exit code is not relied on
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
